// File: led_pkg.sv
/* Shared types, message table and segment patterns for the four-digit display.
   Segments and anodes are active low; digit 0 is the rightmost digit. */
package led_pkg;

	// One hex character shown on one digit
	typedef logic [3:0] char_t;

	// Display state, four states per digit and 16 per full refresh
	typedef logic [3:0] state_t;

	// Active-low anodes, bit d lights digit d
	typedef logic [3:0] anode_t;

	// Active-low segments, bit 0 is segment a and bit 6 is segment g
	typedef logic [6:0] seg_t;

	// Characters for the four digits, ch3 is the leftmost
	typedef struct packed {
		char_t ch3;
		char_t ch2;
		char_t ch1;
		char_t ch0;
	} digit_chars_t;

	// Registered board output
	typedef struct packed {
		anode_t anodes;
		seg_t   seg;
	} display_t;

	localparam int unsigned MSG_LEN = 16;

	// Position of the display window inside the message
	typedef logic [$clog2(MSG_LEN)-1:0] offset_t;

	localparam char_t MESSAGE [MSG_LEN] = '{
		4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8,
		4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF, 4'h0
	};

	localparam anode_t ANODES_OFF = '1;
	localparam seg_t   SEG_BLANK  = '1;

	// Hex glyphs, bit order g f e d c b a
	function automatic seg_t seg_of(input char_t c);
		case (c)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

endpackage

// File: led_state_counter.sv
/* Steps the display state 0..15 once every STATE_DIV clock cycles.
   STATE_DIV sets the refresh rate and must be at least 1. */
module led_state_counter
	import led_pkg::*;
#(
	parameter int unsigned STATE_DIV = 50000
)
(
	input  logic   clk,
	input  logic   rst,
	output state_t state
);

	localparam int unsigned DIV_W = (STATE_DIV > 1) ? $clog2(STATE_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(STATE_DIV - 1);

	logic [DIV_W-1:0] prescale;

	// Prescaler wraps after STATE_DIV cycles and steps the state
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prescale <= '0;
			state    <= '0;
		end
		else if (prescale == DIV_LAST)
		begin
			prescale <= '0;
			// 4-bit state wraps from 15 back to 0 on its own
			state    <= state + state_t'(1);
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// File: btn_debounce.sv
/* Debounces an asynchronous active-high push-button into one pulse per press.
   Both press and release must hold for DEBOUNCE_CYCLES cycles to count. */
module btn_debounce #(
	parameter int unsigned DEBOUNCE_CYCLES = 500000
)
(
	input  logic clk,
	input  logic rst,
	input  logic r_btn,
	output logic press
);

	localparam int unsigned CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic             sync_0;
	logic             sync_1;
	logic [CNT_W-1:0] stable_cnt;
	logic             level;
	logic             level_d;

	// Two-flop synchronizer for the raw button
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sync_0 <= 1'b0;
			sync_1 <= 1'b0;
		end
		else
		begin
			sync_0 <= r_btn;
			sync_1 <= sync_0;
		end
	end

	// Count while the input differs from the debounced level
	// Any return to the old level restarts the count
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stable_cnt <= '0;
			level      <= 1'b0;
		end
		else if (sync_1 == level)
		begin
			stable_cnt <= '0;
		end
		else if (stable_cnt == CNT_LAST)
		begin
			stable_cnt <= '0;
			level      <= sync_1;
		end
		else
		begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

	// One-cycle pulse on the rising edge of the debounced level
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			level_d <= 1'b0;
			press   <= 1'b0;
		end
		else
		begin
			level_d <= level;
			press   <= level & ~level_d;
		end
	end

endmodule

// File: led_message_shifter.sv
/* Shows a four-character window of MESSAGE and scrolls it left on each press.
   The window wraps around the end of the message. */
module led_message_shifter
	import led_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         press,
	output digit_chars_t chars
);

	offset_t offset;

	// Character k positions after the window start, wrapped to the message
	function automatic char_t msg_at(input offset_t base, input int unsigned k);
		int unsigned idx;
		idx = (int'(base) + k) % MSG_LEN;
		return MESSAGE[idx];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			offset <= '0;
		end
		else if (press)
		begin
			if (offset == offset_t'(MSG_LEN - 1))
				offset <= '0;
			else
				offset <= offset + offset_t'(1);
		end
	end

	// Leftmost digit shows the window start so the text reads left to right
	always_comb
	begin
		chars.ch3 = msg_at(offset, 0);
		chars.ch2 = msg_at(offset, 1);
		chars.ch1 = msg_at(offset, 2);
		chars.ch0 = msg_at(offset, 3);
	end

endmodule

// File: led_state_driver.sv
/* Maps the display state to active-low anodes and the character to decode.
   Each digit is lit in one state and its character is held three states before. */
module led_state_driver
	import led_pkg::*;
(
	input  state_t       state,
	input  digit_chars_t chars,
	output anode_t       anodes,
	output char_t        sel_char
);

	logic [1:0] digit;
	logic       lit;

	// Guard states carry the next digit's character with every anode off
	always_comb
	begin
		case (state)
			4'd15, 4'd0, 4'd1:
			begin
				digit = 2'd0;
				lit   = 1'b0;
			end
			4'd2:
			begin
				digit = 2'd0;
				lit   = 1'b1;
			end
			4'd3, 4'd4, 4'd5:
			begin
				digit = 2'd1;
				lit   = 1'b0;
			end
			4'd6:
			begin
				digit = 2'd1;
				lit   = 1'b1;
			end
			4'd7, 4'd8, 4'd9:
			begin
				digit = 2'd2;
				lit   = 1'b0;
			end
			4'd10:
			begin
				digit = 2'd2;
				lit   = 1'b1;
			end
			4'd11, 4'd12, 4'd13:
			begin
				digit = 2'd3;
				lit   = 1'b0;
			end
			default:
			begin
				// State 14 lights the leftmost digit
				digit = 2'd3;
				lit   = 1'b1;
			end
		endcase
	end

	// Only the lit digit pulls its anode low
	always_comb
	begin
		anodes = ANODES_OFF;
		if (lit)
			anodes[digit] = 1'b0;
	end

	always_comb
	begin
		case (digit)
			2'd0: sel_char = chars.ch0;
			2'd1: sel_char = chars.ch1;
			2'd2: sel_char = chars.ch2;
			default: sel_char = chars.ch3;
		endcase
	end

endmodule

// File: led_seg_decoder.sv
/* Decodes the selected character and registers it with the anodes.
   Output lags the state by one cycle; reset turns every digit off. */
module led_seg_decoder
	import led_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  anode_t   anodes,
	input  char_t    sel_char,
	output display_t disp
);

	seg_t seg_next;

	always_comb
	begin
		seg_next = seg_of(sel_char);
	end

	// Anodes and segments change on the same edge so the board sees no glitch
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			disp.anodes <= ANODES_OFF;
			disp.seg    <= SEG_BLANK;
		end
		else
		begin
			disp.anodes <= anodes;
			disp.seg    <= seg_next;
		end
	end

endmodule

// File: led_display_top.sv
/* Four-digit scrolling message display with one debounced push-button.
   Default parameters suit a 100 MHz board clock; shorten both for simulation. */
module led_display_top
	import led_pkg::*;
#(
	parameter int unsigned STATE_DIV       = 50000,
	parameter int unsigned DEBOUNCE_CYCLES = 500000
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     r_btn,
	output display_t disp
);

	state_t       state;
	logic         press;
	digit_chars_t chars;
	anode_t       anodes;
	char_t        sel_char;

	led_state_counter #(
		.STATE_DIV (STATE_DIV)
	) i_state_counter (
		.clk   (clk),
		.rst   (rst),
		.state (state)
	);

	btn_debounce #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) i_btn_debounce (
		.clk   (clk),
		.rst   (rst),
		.r_btn (r_btn),
		.press (press)
	);

	led_message_shifter i_message_shifter (
		.clk   (clk),
		.rst   (rst),
		.press (press),
		.chars (chars)
	);

	// Combinational mapping from state to anodes and character
	led_state_driver i_state_driver (
		.state    (state),
		.chars    (chars),
		.anodes   (anodes),
		.sel_char (sel_char)
	);

	led_seg_decoder i_seg_decoder (
		.clk      (clk),
		.rst      (rst),
		.anodes   (anodes),
		.sel_char (sel_char),
		.disp     (disp)
	);

endmodule

// File: led_display_props.sv
/* Assertions on the registered display outputs, bound into led_seg_decoder.
   A press may change the segments of a lit digit at any time, so only the anodes are checked. */
module led_display_props
	import led_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input display_t disp
);
	timeunit 1ns;
	timeprecision 1ps;

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	// Never more than one digit lit
	one_anode_low: assert property (@(posedge clk) disable iff (rst)
		$countones(~disp.anodes) <= 1)
	else
	begin
		fail_count++;
		$error("more than one anode low, anodes %h", disp.anodes);
	end

	// Guard states keep every digit off between two lit digits
	lit_after_blank: assert property (@(posedge clk) disable iff (rst)
		(disp.anodes != ANODES_OFF && !$stable(disp.anodes)) |-> $past(disp.anodes) == ANODES_OFF)
	else
	begin
		fail_count++;
		$error("digit lit without a blank cycle before it, anodes %h", disp.anodes);
	end

endmodule

bind led_seg_decoder led_display_props i_props (
	.clk  (clk),
	.rst  (rst),
	.disp (disp)
);

// File: tb_led_display.sv
/* Testbench for led_display_top with short prescaler and debounce times.
   Reads button commands from led_display_stimulus.txt and stops at the first mismatch. */
module tb_led_display
	import led_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned STATE_DIV       = 4;
	localparam int unsigned DEBOUNCE_CYCLES = 8;
	localparam int unsigned RELEASE_CYCLES  = 20;
	localparam int unsigned WAIT_LIMIT      = 200;
	localparam string       STIM_FILE       = "led_display_stimulus.txt";
	localparam anode_t      ALL_OFF         = '1;
	localparam seg_t        ALL_BLANK       = '1;

	logic     clk;
	logic     rst;
	logic     r_btn;
	display_t disp;

	// Seed for $random, no random stimulus at present
	int seed = 8;

	led_display_top #(
		.STATE_DIV       (STATE_DIV),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) i_dut (
		.clk   (clk),
		.rst   (rst),
		.r_btn (r_btn),
		.disp  (disp)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Message counts up 1 to F and ends with 0
	function automatic char_t msg_char(input int unsigned pos);
		return char_t'((pos + 1) % MSG_LEN);
	endfunction

	// Leftmost digit shows the window start
	function automatic char_t expected_char(input int unsigned offset, input int unsigned digit);
		return msg_char((offset + 3 - digit) % MSG_LEN);
	endfunction

	// Lit segments listed active high as g f e d c b a, then inverted
	function automatic seg_t glyph(input char_t c);
		seg_t on;
		case (c)
			4'h0: on = 7'b0111111;
			4'h1: on = 7'b0000110;
			4'h2: on = 7'b1011011;
			4'h3: on = 7'b1001111;
			4'h4: on = 7'b1100110;
			4'h5: on = 7'b1101101;
			4'h6: on = 7'b1111101;
			4'h7: on = 7'b0000111;
			4'h8: on = 7'b1111111;
			4'h9: on = 7'b1101111;
			4'hA: on = 7'b1110111;
			4'hB: on = 7'b1111100;
			4'hC: on = 7'b0111001;
			4'hD: on = 7'b1011110;
			4'hE: on = 7'b1111001;
			default: on = 7'b1110001;
		endcase
		return ~on;
	endfunction

	function automatic anode_t lit_anodes(input int unsigned digit);
		anode_t a;
		a = '1;
		a[digit] = 1'b0;
		return a;
	endfunction

	task automatic fail_and_stop();
		$display("=== FAIL ===");
		$fatal(1, "testbench stopped on the first error");
	endtask

	task automatic check_anodes(input string name, input anode_t act, input anode_t exp);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
			fail_and_stop();
		end
	endtask

	task automatic check_seg(input string name, input seg_t act, input seg_t exp);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
			fail_and_stop();
		end
	endtask

	task automatic check_display(input string name, input display_t act, input display_t exp);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
			fail_and_stop();
		end
	endtask

	// Step to 1 ns after the next rising edge, where inputs change and outputs are read
	task automatic tick();
		@(posedge clk);
		#1;
		if (i_dut.i_seg_decoder.i_props.fail_count != 0)
		begin
			$display("An assertion on the display outputs failed");
			fail_and_stop();
		end
	endtask

	// Stops on the first cycle of a digit 0 lit period
	task automatic wait_digit0_start();
		int unsigned n;
		n = 0;
		while (disp.anodes === lit_anodes(0))
		begin
			tick();
			n++;
			if (n > WAIT_LIMIT)
			begin
				$display("Timed out waiting for digit 0 to turn off");
				fail_and_stop();
			end
		end
		n = 0;
		while (disp.anodes !== lit_anodes(0))
		begin
			tick();
			n++;
			if (n > WAIT_LIMIT)
			begin
				$display("Timed out waiting for digit 0 to light");
				fail_and_stop();
			end
		end
	endtask

	// One full refresh: each digit lit for STATE_DIV cycles, then 3*STATE_DIV blank
	task automatic check_refresh(input int unsigned offset);
		display_t exp;
		wait_digit0_start();
		for (int d = 0; d < 4; d++)
		begin
			exp.anodes = lit_anodes(d);
			exp.seg    = glyph(expected_char(offset, d));
			for (int i = 0; i < STATE_DIV; i++)
			begin
				check_display("disp", disp, exp);
				tick();
			end
			for (int i = 0; i < 3 * STATE_DIV; i++)
			begin
				check_anodes("disp.anodes", disp.anodes, ALL_OFF);
				tick();
			end
		end
	endtask

	task automatic drive_button(input int unsigned high_cycles);
		r_btn = 1'b1;
		repeat (high_cycles) tick();
		r_btn = 1'b0;
		repeat (RELEASE_CYCLES) tick();
	endtask

	initial
	begin
		int               fd;
		int               count;
		int unsigned      high_cycles;
		int unsigned      exp_offset;
		int unsigned      commands;
		logic [8*128-1:0] line;
		logic [8*16-1:0]  cmd;
		rst      = 1'b1;
		r_btn    = 1'b0;
		commands = 0;

		repeat (10)
		begin
			tick();
			check_anodes("disp.anodes", disp.anodes, ALL_OFF);
			check_seg("disp.seg", disp.seg, ALL_BLANK);
		end
		rst = 1'b0;

		// State 0 is a guard state, every digit off with digit 0's character already selected
		tick();
		check_anodes("disp.anodes", disp.anodes, ALL_OFF);
		check_seg("disp.seg", disp.seg, glyph(expected_char(0, 0)));

		// Window at offset 0 reads 1 2 3 4
		check_refresh(0);

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file %s", STIM_FILE);
			fail_and_stop();
		end
		while (!$feof(fd))
		begin
			line = '0;
			if ($fgets(line, fd) == 0)
				break;
			// Comment and empty lines do not yield three fields
			count = $sscanf(line, "%s %d %h", cmd, high_cycles, exp_offset);
			if (count != 3)
				continue;
			if (cmd == "glitch" && high_cycles >= DEBOUNCE_CYCLES)
			begin
				$display("A glitch of %0d cycles is not shorter than the debounce time", high_cycles);
				fail_and_stop();
			end
			else if (cmd != "press" && cmd != "glitch")
			begin
				$display("Unknown command in the stimulus file: %0s", cmd);
				fail_and_stop();
			end
			drive_button(high_cycles);
			check_refresh(exp_offset);
			commands++;
		end
		$fclose(fd);

		if (commands == 0)
		begin
			$display("The stimulus file holds no commands");
			fail_and_stop();
		end

		if (i_dut.i_seg_decoder.i_props.fail_count == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			$display("An assertion on the display outputs failed");
			fail_and_stop();
		end
	end

endmodule

// File: led_display_stimulus.txt
# command  high_cycles  expected_offset_hex
# press is followed by 20 released cycles and glitch stays shorter than 8 cycles
glitch 3 0
press 10 1
press 12 2
glitch 7 2
press 8 3
press 9 4
press 10 5
glitch 1 5
press 15 6
press 10 7
press 10 8
press 11 9
press 10 a
press 10 b
press 10 c
press 10 d
press 10 e
press 10 f
glitch 6 f
press 10 0
glitch 4 0

// File: sim.f
led_pkg.sv
led_state_counter.sv
btn_debounce.sv
led_message_shifter.sv
led_state_driver.sv
led_seg_decoder.sv
led_display_top.sv
led_display_props.sv
tb_led_display.sv

// File: Bender.yml
package:
  name: led_display

sources:
  - led_pkg.sv
  - led_state_counter.sv
  - btn_debounce.sv
  - led_message_shifter.sv
  - led_state_driver.sv
  - led_seg_decoder.sv
  - led_display_top.sv
  - target: test
    files:
      - led_display_props.sv
      - tb_led_display.sv
